//--- src/core_pkg.sv
package core_pkg;

    // datapath and RAM port sizes
    localparam int word_width     = 32;
    localparam int address_width  = 16;
    localparam int reg_addr_width = 5;

    typedef logic [word_width-1:0]     word_t;
    typedef logic [reg_addr_width-1:0] reg_addr_t;

    // one instruction is four bytes
    localparam word_t pc_step = 32'd4;

    // fixed per-instruction state sequence
    typedef enum logic [3:0] {
        state_init,
        state_fetch,
        state_fetch_wait,
        state_decode,
        state_registers,
        state_execute,
        state_load,
        state_load_wait,
        state_store,
        state_retire,
        state_halted
    } core_state_t;

endpackage

//--- src/isa_pkg.sv
package isa_pkg;

    // major opcodes, instruction bits 6:0
    localparam logic [6:0] opcode_op_imm = 7'b0010011;
    localparam logic [6:0] opcode_op_reg = 7'b0110011;
    localparam logic [6:0] opcode_lui    = 7'b0110111;
    localparam logic [6:0] opcode_jal    = 7'b1101111;
    localparam logic [6:0] opcode_jalr   = 7'b1100111;
    localparam logic [6:0] opcode_branch = 7'b1100011;
    localparam logic [6:0] opcode_load   = 7'b0000011;
    localparam logic [6:0] opcode_store  = 7'b0100011;
    localparam logic [6:0] opcode_system = 7'b1110011;

    // branch conditions
    localparam logic [2:0] funct3_beq  = 3'b000;
    localparam logic [2:0] funct3_bne  = 3'b001;
    localparam logic [2:0] funct3_blt  = 3'b100;
    localparam logic [2:0] funct3_bge  = 3'b101;
    localparam logic [2:0] funct3_bltu = 3'b110;
    localparam logic [2:0] funct3_bgeu = 3'b111;

    // alu variants, shared by op_imm and op_reg
    localparam logic [2:0] funct3_add_sub = 3'b000;
    localparam logic [2:0] funct3_sll     = 3'b001;
    localparam logic [2:0] funct3_slt     = 3'b010;
    localparam logic [2:0] funct3_sltu    = 3'b011;
    localparam logic [2:0] funct3_xor     = 3'b100;
    localparam logic [2:0] funct3_srl_sra = 3'b101;
    localparam logic [2:0] funct3_or      = 3'b110;
    localparam logic [2:0] funct3_and     = 3'b111;

    // lw and sw, the only access size
    localparam logic [2:0] funct3_word = 3'b010;

    // system immediate for ebreak
    localparam logic [11:0] ebreak_imm = 12'd1;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_none
    } alu_op_t;

    typedef enum logic [3:0] {
        class_alu_imm, class_alu_reg, class_lui, class_jal, class_jalr,
        class_branch, class_load, class_store, class_halt, class_nop
    } inst_class_t;

    typedef struct packed {
        inst_class_t         inst_class;
        core_pkg::reg_addr_t rd;
        core_pkg::reg_addr_t rs1;
        core_pkg::reg_addr_t rs2;
        logic [2:0]          funct3;
        // instruction bit 30, picks sub and sra
        logic                alt;
        core_pkg::word_t     imm;
    } decoded_inst_t;

endpackage

//--- src/reg_file_if.sv
interface reg_file_if;
    import core_pkg::*;

    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    word_t     rs1_data;
    word_t     rs2_data;
    reg_addr_t rd_addr;
    logic      rd_write;
    word_t     rd_data;

    modport bank (
        input  rs1_addr, rs2_addr, rd_addr, rd_write, rd_data,
        output rs1_data, rs2_data
    );

    // store data comes straight from the rs2 read port
    modport control (
        output rs1_addr, rs2_addr, rd_addr, rd_write, rd_data,
        input  rs2_data
    );

    modport operands (
        input rs1_data, rs2_data
    );

endinterface

//--- src/register_file.sv
module register_file (
    input logic      clock,
    reg_file_if.bank regs
);
    import core_pkg::*;

    word_t bank [2**reg_addr_width];

    // x0 reads as zero whatever the array holds
    always_comb begin
        if (regs.rs1_addr == '0) begin
            regs.rs1_data = '0;
        end else begin
            regs.rs1_data = bank[regs.rs1_addr];
        end
    end

    always_comb begin
        if (regs.rs2_addr == '0) begin
            regs.rs2_data = '0;
        end else begin
            regs.rs2_data = bank[regs.rs2_addr];
        end
    end

    always_ff @(posedge clock) begin
        if (regs.rd_write && (regs.rd_addr != '0)) begin
            bank[regs.rd_addr] <= regs.rd_data;
        end
    end

endmodule

//--- src/inst_decoder.sv
module inst_decoder (
    input  logic                   clock,
    input  logic                   load_inst,
    input  core_pkg::word_t        inst_word,
    output isa_pkg::decoded_inst_t decoded
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t      inst_q;
    logic [6:0] opcode;
    word_t      imm_i;
    word_t      imm_s;
    word_t      imm_b;
    word_t      imm_u;
    word_t      imm_j;

    // held for the whole instruction, reloaded only in decode
    always_ff @(posedge clock) begin
        if (load_inst) begin
            inst_q <= inst_word;
        end
    end

    assign opcode = inst_q[6:0];

    // immediate formats, all sign extended from bit 31
    assign imm_i = {{20{inst_q[31]}}, inst_q[31:20]};
    assign imm_s = {{20{inst_q[31]}}, inst_q[31:25], inst_q[11:7]};
    assign imm_b = {{19{inst_q[31]}}, inst_q[31], inst_q[7], inst_q[30:25],
                    inst_q[11:8], 1'b0};
    assign imm_u = {inst_q[31:12], 12'b0};
    assign imm_j = {{11{inst_q[31]}}, inst_q[31], inst_q[19:12], inst_q[20],
                    inst_q[30:21], 1'b0};

    always_comb begin
        decoded.rd     = inst_q[11:7];
        decoded.rs1    = inst_q[19:15];
        decoded.rs2    = inst_q[24:20];
        decoded.funct3 = inst_q[14:12];
        decoded.alt    = inst_q[30];

        // anything not listed retires as a no-op
        decoded.inst_class = class_nop;
        decoded.imm        = imm_i;

        case (opcode)
            opcode_op_imm: decoded.inst_class = class_alu_imm;
            opcode_op_reg: decoded.inst_class = class_alu_reg;
            opcode_jalr:   decoded.inst_class = class_jalr;
            opcode_load:   decoded.inst_class = class_load;
            opcode_lui: begin
                decoded.inst_class = class_lui;
                decoded.imm        = imm_u;
            end
            opcode_jal: begin
                decoded.inst_class = class_jal;
                decoded.imm        = imm_j;
            end
            opcode_branch: begin
                decoded.inst_class = class_branch;
                decoded.imm        = imm_b;
            end
            opcode_store: begin
                decoded.inst_class = class_store;
                decoded.imm        = imm_s;
            end
            opcode_system: begin
                // ecall and friends fall through as no-ops
                if (inst_q[31:20] == ebreak_imm) begin
                    decoded.inst_class = class_halt;
                end
            end
            default: begin
            end
        endcase
    end

endmodule

//--- src/execute_unit.sv
module execute_unit (
    input  logic                   clock,
    input  isa_pkg::decoded_inst_t decoded,
    reg_file_if.operands           regs,
    input  core_pkg::word_t        pc,
    output core_pkg::word_t        alu_result,
    output logic                   branch_taken
);
    import core_pkg::*;
    import isa_pkg::*;

    word_t   operand1;
    word_t   operand2;
    logic    is_shift;
    alu_op_t funct3_op;
    alu_op_t alu_op;
    word_t   alu_value;

    assign is_shift = (decoded.funct3 == funct3_sll) || (decoded.funct3 == funct3_srl_sra);

    always_comb begin
        case (decoded.inst_class)
            class_alu_imm, class_alu_reg, class_jalr, class_load, class_store:
                operand1 = regs.rs1_data;
            class_lui:
                operand1 = decoded.imm;
            class_jal, class_branch:
                operand1 = pc;
            default:
                operand1 = '0;
        endcase
    end

    // shift amounts keep only their low 5 bits
    always_comb begin
        case (decoded.inst_class)
            class_alu_imm:
                operand2 = is_shift ? word_t'(decoded.imm[4:0]) : decoded.imm;
            class_alu_reg:
                operand2 = is_shift ? word_t'(regs.rs2_data[4:0]) : regs.rs2_data;
            class_jal, class_jalr, class_branch, class_load, class_store:
                operand2 = decoded.imm;
            default:
                operand2 = '0;
        endcase
    end

    always_comb begin
        case (decoded.funct3)
            funct3_add_sub: funct3_op = alu_add;
            funct3_sll:     funct3_op = alu_sll;
            funct3_slt:     funct3_op = alu_slt;
            funct3_sltu:    funct3_op = alu_sltu;
            funct3_xor:     funct3_op = alu_xor;
            funct3_srl_sra: funct3_op = decoded.alt ? alu_sra : alu_srl;
            funct3_or:      funct3_op = alu_or;
            default:        funct3_op = alu_and;
        endcase
    end

    always_comb begin
        case (decoded.inst_class)
            class_alu_imm:
                alu_op = funct3_op;
            // bit 30 only means sub for the register form
            class_alu_reg:
                alu_op = (funct3_op == alu_add && decoded.alt) ? alu_sub : funct3_op;
            class_lui, class_jal, class_jalr, class_branch, class_load, class_store:
                alu_op = alu_add;
            default:
                alu_op = alu_none;
        endcase
    end

    always_comb begin
        case (alu_op)
            alu_add:  alu_value = operand1 + operand2;
            alu_sub:  alu_value = operand1 - operand2;
            alu_sll:  alu_value = operand1 << operand2;
            alu_slt:  alu_value = word_t'($signed(operand1) < $signed(operand2));
            alu_sltu: alu_value = word_t'(operand1 < operand2);
            alu_xor:  alu_value = operand1 ^ operand2;
            alu_srl:  alu_value = operand1 >> operand2;
            alu_sra:  alu_value = word_t'($signed(operand1) >>> operand2);
            alu_or:   alu_value = operand1 | operand2;
            alu_and:  alu_value = operand1 & operand2;
            default:  alu_value = '0;
        endcase
    end

    always_ff @(posedge clock) begin
        alu_result <= alu_value;
    end

    always_comb begin
        case (decoded.funct3)
            funct3_beq:  branch_taken = regs.rs1_data == regs.rs2_data;
            funct3_bne:  branch_taken = regs.rs1_data != regs.rs2_data;
            funct3_blt:  branch_taken = $signed(regs.rs1_data) < $signed(regs.rs2_data);
            funct3_bge:  branch_taken = $signed(regs.rs1_data) >= $signed(regs.rs2_data);
            funct3_bltu: branch_taken = regs.rs1_data < regs.rs2_data;
            funct3_bgeu: branch_taken = regs.rs1_data >= regs.rs2_data;
            default:     branch_taken = 1'b0;
        endcase
    end

endmodule

//--- src/core_control.sv
module core_control (
    input  logic                               clock,
    input  logic                               reset_n,
    input  logic                               run,
    input  isa_pkg::decoded_inst_t             decoded,
    input  core_pkg::word_t                    alu_result,
    input  logic                               branch_taken,
    reg_file_if.control                        regs,
    output logic                               load_inst,
    output core_pkg::word_t                    pc,
    output logic                               halted,
    output logic [core_pkg::address_width-1:0] inst_ram_address,
    output logic [core_pkg::address_width-1:0] data_ram_address,
    output core_pkg::word_t                    data_ram_write_data,
    output logic                               data_ram_write,
    input  core_pkg::word_t                    data_ram_read_result
);
    import core_pkg::*;
    import isa_pkg::*;

    core_state_t state;
    logic        branch_taken_q;
    logic        is_jump;
    logic        writes_rd;
    word_t       pc_next_seq;

    // operands are read straight from the held instruction
    assign regs.rs1_addr = decoded.rs1;
    assign regs.rs2_addr = decoded.rs2;

    assign load_inst   = run && (state == state_decode);
    assign pc_next_seq = pc + pc_step;
    assign is_jump     = (decoded.inst_class == class_jal) || (decoded.inst_class == class_jalr);

    always_comb begin
        case (decoded.inst_class)
            class_alu_imm, class_alu_reg, class_lui, class_jal, class_jalr, class_load:
                writes_rd = 1'b1;
            default:
                writes_rd = 1'b0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!reset_n) begin
            state          <= state_init;
            pc             <= '0;
            halted         <= 1'b0;
            data_ram_write <= 1'b0;
            regs.rd_write  <= 1'b0;
        end else if (run) begin
            case (state)
                state_init: state <= state_fetch;
                state_fetch: begin
                    // previous writeback lands on this edge
                    regs.rd_write <= 1'b0;
                    state         <= state_fetch_wait;
                end
                state_fetch_wait: state <= state_decode;
                state_decode:     state <= state_registers;
                state_registers: begin
                    if (decoded.inst_class == class_halt) begin
                        halted <= 1'b1;
                        state  <= state_halted;
                    end else begin
                        state <= state_execute;
                    end
                end
                state_execute: begin
                    case (decoded.inst_class)
                        class_load:  state <= state_load;
                        class_store: state <= state_store;
                        default:     state <= state_retire;
                    endcase
                end
                state_load:      state <= state_load_wait;
                state_load_wait: state <= state_retire;
                state_store: begin
                    data_ram_write <= 1'b1;
                    state          <= state_retire;
                end
                state_retire: begin
                    data_ram_write <= 1'b0;
                    regs.rd_write  <= writes_rd && (decoded.rd != '0);
                    if (is_jump) begin
                        pc <= {alu_result[word_width-1:1], 1'b0};
                    end else if ((decoded.inst_class == class_branch) && branch_taken_q) begin
                        pc <= alu_result;
                    end else begin
                        pc <= pc_next_seq;
                    end
                    state <= state_fetch;
                end
                // only reset leaves here
                state_halted: state <= state_halted;
                default:      state <= state_init;
            endcase
        end
    end

    // addresses, store data and writeback value
    always_ff @(posedge clock) begin
        if (run) begin
            case (state)
                state_fetch:   inst_ram_address <= pc[address_width-1:0];
                state_execute: branch_taken_q <= branch_taken;
                state_load:    data_ram_address <= alu_result[address_width-1:0];
                state_store: begin
                    data_ram_address    <= alu_result[address_width-1:0];
                    data_ram_write_data <= regs.rs2_data;
                end
                state_retire: begin
                    regs.rd_addr <= decoded.rd;
                    if (is_jump) begin
                        regs.rd_data <= pc_next_seq;
                    end else if (decoded.inst_class == class_load) begin
                        regs.rd_data <= data_ram_read_result;
                    end else begin
                        regs.rd_data <= alu_result;
                    end
                end
                default: begin
                end
            endcase
        end
    end

endmodule

//--- src/shader_core.sv
module shader_core (
    input  logic                               clock,
    input  logic                               reset_n,
    input  logic                               run,
    output logic                               halted,
    output logic [core_pkg::address_width-1:0] inst_ram_address,
    output logic [core_pkg::address_width-1:0] data_ram_address,
    input  core_pkg::word_t                    inst_ram_read_result,
    input  core_pkg::word_t                    data_ram_read_result,
    output core_pkg::word_t                    data_ram_write_data,
    output logic                               data_ram_write
);
    import core_pkg::*;
    import isa_pkg::*;

    decoded_inst_t decoded;
    word_t         alu_result;
    word_t         pc;
    logic          branch_taken;
    logic          load_inst;

    reg_file_if regs_if ();

    register_file register_file_inst (
        .clock (clock),
        .regs  (regs_if.bank)
    );

    inst_decoder inst_decoder_inst (
        .clock     (clock),
        .load_inst (load_inst),
        .inst_word (inst_ram_read_result),
        .decoded   (decoded)
    );

    execute_unit execute_unit_inst (
        .clock        (clock),
        .decoded      (decoded),
        .regs         (regs_if.operands),
        .pc           (pc),
        .alu_result   (alu_result),
        .branch_taken (branch_taken)
    );

    core_control core_control_inst (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .decoded              (decoded),
        .alu_result           (alu_result),
        .branch_taken         (branch_taken),
        .regs                 (regs_if.control),
        .load_inst            (load_inst),
        .pc                   (pc),
        .halted               (halted),
        .inst_ram_address     (inst_ram_address),
        .data_ram_address     (data_ram_address),
        .data_ram_write_data  (data_ram_write_data),
        .data_ram_write       (data_ram_write),
        .data_ram_read_result (data_ram_read_result)
    );

endmodule

//--- verif/shader_core_tb.sv
module shader_core_tb;
    import core_pkg::*;
    import isa_pkg::*;

    // instructions over all programs, the run test counted twice
    localparam int program_inst_total = 115;
    localparam int timeout_cycles     = program_inst_total * 8 * 2 + 300;

    logic clock;
    logic reset_n;
    logic run;
    logic halted;
    logic [address_width-1:0] inst_ram_address;
    logic [address_width-1:0] data_ram_address;
    word_t inst_ram_read_result;
    word_t data_ram_read_result;
    word_t data_ram_write_data;
    logic  data_ram_write;

    word_t inst_mem [1024];
    word_t data_mem [1024];
    word_t prog[$];
    word_t wr_addr[$];
    word_t wr_data[$];
    word_t exp_addr[$];
    word_t exp_data[$];
    int    cycle_count;
    bit    with_stalls;

    shader_core shader_core_inst (
        .clock                (clock),
        .reset_n              (reset_n),
        .run                  (run),
        .halted               (halted),
        .inst_ram_address     (inst_ram_address),
        .data_ram_address     (data_ram_address),
        .inst_ram_read_result (inst_ram_read_result),
        .data_ram_read_result (data_ram_read_result),
        .data_ram_write_data  (data_ram_write_data),
        .data_ram_write       (data_ram_write)
    );

    initial begin
        clock = 1'b0;
        forever begin
            #50 clock = ~clock;
        end
    end

    task automatic fail_stop();
        $display("Verification failed");
        $fatal(1);
    endtask

    // word-addressed RAM models with one cycle of read latency
    always @(posedge clock) begin
        inst_ram_read_result <= inst_mem[inst_ram_address[11:2]];
    end

    always @(posedge clock) begin
        if (data_ram_write) begin
            assert (run) else begin
                $display("data RAM write seen while run was low");
                fail_stop();
            end
            data_mem[data_ram_address[11:2]] <= data_ram_write_data;
            wr_addr.push_back({16'h0, data_ram_address});
            wr_data.push_back(data_ram_write_data);
        end
        data_ram_read_result <= data_mem[data_ram_address[11:2]];
    end

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > timeout_cycles) begin
            $display("timeout, the core did not halt in time");
            fail_stop();
        end
    end

    // instruction encoders
    function automatic word_t r_type(int f7, int rs2, int rs1, int f3, int rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], opcode_op_reg};
    endfunction

    function automatic word_t i_type(logic [6:0] op, int rd, int f3, int rs1, int imm);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op};
    endfunction

    function automatic word_t addi(int rd, int rs1, int imm);
        return i_type(opcode_op_imm, rd, funct3_add_sub, rs1, imm);
    endfunction

    function automatic word_t load_word(int rd, int rs1, int imm);
        return i_type(opcode_load, rd, funct3_word, rs1, imm);
    endfunction

    function automatic word_t store_word(int rs2, int rs1, int imm);
        return {imm[11:5], rs2[4:0], rs1[4:0], funct3_word, imm[4:0], opcode_store};
    endfunction

    function automatic word_t b_type(int f3, int rs1, int rs2, int imm);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11],
                opcode_branch};
    endfunction

    function automatic word_t u_type(int rd, int imm20);
        return {imm20[19:0], rd[4:0], opcode_lui};
    endfunction

    function automatic word_t j_type(int rd, int imm);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], opcode_jal};
    endfunction

    function automatic word_t ebreak_word();
        return i_type(opcode_system, 0, 0, 0, 1);
    endfunction

    // RV32I branch conditions
    function automatic bit branch_holds(int f3, word_t a, word_t b);
        case (f3[2:0])
            funct3_beq:  return a == b;
            funct3_bne:  return a != b;
            funct3_blt:  return $signed(a) < $signed(b);
            funct3_bge:  return $signed(a) >= $signed(b);
            funct3_bltu: return a < b;
            default:     return a >= b;
        endcase
    endfunction

    // the last window holds the first sw in its store state
    function automatic bit in_stall(int cyc);
        return (cyc >= 3 && cyc <= 7) || (cyc >= 9 && cyc <= 11) ||
               (cyc >= 14 && cyc <= 17) || (cyc >= 36 && cyc <= 37);
    endfunction

    task automatic check_word(string name, word_t got, word_t expected);
        assert (got === expected) else begin
            $display("FAILED %s: got %h, expected %h", name, got, expected);
            fail_stop();
        end
    endtask

    task automatic expect_write(word_t addr, word_t data);
        exp_addr.push_back(addr);
        exp_data.push_back(data);
    endtask

    task automatic compare_writes();
        assert (wr_addr.size() == exp_addr.size()) else begin
            $display("wrong number of data RAM writes: %0d seen, %0d expected",
                     wr_addr.size(), exp_addr.size());
            fail_stop();
        end
        foreach (exp_addr[i]) begin
            check_word("data_ram_address", wr_addr[i], exp_addr[i]);
            check_word("data_ram_write_data", wr_data[i], exp_data[i]);
        end
        exp_addr.delete();
        exp_data.delete();
    endtask

    task automatic fill_data_ram();
        for (int i = 0; i < 1024; i++) begin
            data_mem[i] = 32'h5a00_0000 | i;
        end
    endtask

    // loads the program, resets the core and runs it until halted
    task automatic run_program(output int cycles);
        for (int i = 0; i < 1024; i++) begin
            inst_mem[i] = addi(0, 0, i);
        end
        foreach (prog[i]) begin
            inst_mem[i] = prog[i];
        end
        @(posedge clock);
        reset_n <= 1'b0;
        run     <= 1'b1;
        repeat (10) @(posedge clock);
        reset_n <= 1'b1;
        wr_addr.delete();
        wr_data.delete();
        cycles = 0;
        do begin
            @(posedge clock);
            cycles++;
            run <= !(with_stalls && in_stall(cycles));
            @(negedge clock);
        end while (!halted);
    endtask

    task automatic test_arithmetic();
        word_t a;
        word_t b;
        int    cycles;
        a = 32'h8000_1234;
        b = 32'hffff_fffb;
        prog = '{u_type(1, 20'h80001), addi(1, 1, 12'h234), addi(2, 0, -5),
                 store_word(1, 0, 12'h100),
                 r_type(0, 2, 1, funct3_add_sub, 3), store_word(3, 0, 12'h104),
                 r_type(32, 2, 1, funct3_add_sub, 3), store_word(3, 0, 12'h108),
                 r_type(0, 2, 1, funct3_xor, 3), store_word(3, 0, 12'h10c),
                 r_type(0, 2, 1, funct3_or, 3), store_word(3, 0, 12'h110),
                 r_type(0, 2, 1, funct3_and, 3), store_word(3, 0, 12'h114),
                 r_type(0, 2, 1, funct3_slt, 3), store_word(3, 0, 12'h118),
                 r_type(0, 1, 2, funct3_slt, 3), store_word(3, 0, 12'h11c),
                 r_type(0, 2, 1, funct3_sltu, 3), store_word(3, 0, 12'h120),
                 addi(3, 1, -2048), store_word(3, 0, 12'h124), ebreak_word()};
        run_program(cycles);
        expect_write(32'h100, a);
        expect_write(32'h104, a + b);
        expect_write(32'h108, a - b);
        expect_write(32'h10c, a ^ b);
        expect_write(32'h110, a | b);
        expect_write(32'h114, a & b);
        expect_write(32'h118, word_t'($signed(a) < $signed(b)));
        expect_write(32'h11c, word_t'($signed(b) < $signed(a)));
        expect_write(32'h120, word_t'(a < b));
        expect_write(32'h124, a - 32'd2048);
        compare_writes();
    endtask

    task automatic test_shifts();
        word_t c;
        int    cycles;
        c = 32'hf000_0123;
        // x2 = 35, so only a shift of 3 counts
        prog = '{u_type(1, 20'hf0000), addi(1, 1, 12'h123), addi(2, 0, 35),
                 i_type(opcode_op_imm, 3, funct3_sll, 1, 4), store_word(3, 0, 12'h200),
                 i_type(opcode_op_imm, 3, funct3_srl_sra, 1, 8), store_word(3, 0, 12'h204),
                 i_type(opcode_op_imm, 3, funct3_srl_sra, 1, 12'h408),
                 store_word(3, 0, 12'h208),
                 r_type(0, 2, 1, funct3_sll, 3), store_word(3, 0, 12'h20c),
                 r_type(0, 2, 1, funct3_srl_sra, 3), store_word(3, 0, 12'h210),
                 r_type(32, 2, 1, funct3_srl_sra, 3), store_word(3, 0, 12'h214),
                 u_type(9, 20'h12345), store_word(9, 0, 12'h218), ebreak_word()};
        run_program(cycles);
        expect_write(32'h200, c << 4);
        expect_write(32'h204, c >> 8);
        expect_write(32'h208, word_t'($signed(c) >>> 8));
        expect_write(32'h20c, c << 3);
        expect_write(32'h210, c >> 3);
        expect_write(32'h214, word_t'($signed(c) >>> 3));
        expect_write(32'h218, 32'h1234_5000);
        compare_writes();
    endtask

    task automatic test_load_store();
        int cycles;
        fill_data_ram();
        data_mem[12'h200 >> 2] = 32'h1234_5678;
        data_mem[12'h204 >> 2] = 32'hfedc_ba98;
        prog = '{load_word(1, 0, 12'h200), load_word(2, 0, 12'h204),
                 r_type(0, 2, 1, funct3_add_sub, 3), store_word(3, 0, 12'h300),
                 addi(4, 1, -1), store_word(4, 0, 12'h304),
                 addi(0, 1, 5), store_word(0, 0, 12'h308),
                 load_word(0, 0, 12'h200), store_word(0, 0, 12'h30c),
                 addi(5, 0, 12'h200), load_word(6, 5, 4), store_word(6, 5, -4),
                 ebreak_word()};
        run_program(cycles);
        expect_write(32'h300, 32'h1234_5678 + 32'hfedc_ba98);
        expect_write(32'h304, 32'h1234_5677);
        expect_write(32'h308, 32'h0);
        expect_write(32'h30c, 32'h0);
        expect_write(32'h1fc, 32'hfedc_ba98);
        compare_writes();
        check_word("data_mem[0x1fc]", data_mem[12'h1fc >> 2], 32'hfedc_ba98);
    endtask

    task automatic test_control_flow();
        int    kinds [6];
        int    rs1_sel [12];
        int    rs2_sel [12];
        word_t vals [3];
        int    pj;
        int    pa;
        int    cycles;
        kinds   = '{funct3_beq, funct3_bne, funct3_blt, funct3_bge, funct3_bltu, funct3_bgeu};
        // each kind once taken and once not taken, with x1 = 5 and x2 = -3
        rs1_sel = '{1, 1, 1, 1, 2, 1, 1, 2, 1, 2, 2, 1};
        rs2_sel = '{1, 2, 2, 1, 1, 2, 2, 1, 2, 1, 1, 2};
        vals    = '{32'h0, 32'd5, 32'hffff_fffd};
        prog    = '{addi(1, 0, 5), addi(2, 0, -3), addi(31, 0, 12'h77)};
        for (int k = 0; k < 12; k++) begin
            prog.push_back(b_type(kinds[k / 2], rs1_sel[k], rs2_sel[k], 8));
            prog.push_back(store_word(31, 0, 12'h400 + 4 * k));
            if (!branch_holds(kinds[k / 2], vals[rs1_sel[k]], vals[rs2_sel[k]])) begin
                expect_write(32'h400 + 4 * k, 32'h77);
            end
        end
        pj = prog.size() * 4;
        prog.push_back(j_type(10, 12));
        prog.push_back(store_word(31, 0, 12'h500));
        prog.push_back(store_word(31, 0, 12'h504));
        prog.push_back(store_word(10, 0, 12'h600));
        pa = prog.size() * 4;
        // target with bit 0 set, the core clears it
        prog.push_back(addi(11, 0, pa + 13));
        prog.push_back(i_type(opcode_jalr, 12, 0, 11, 0));
        prog.push_back(store_word(31, 0, 12'h508));
        // its link shows the PC that jalr left behind
        prog.push_back(j_type(13, 8));
        prog.push_back(store_word(31, 0, 12'h50c));
        prog.push_back(store_word(12, 0, 12'h604));
        prog.push_back(store_word(13, 0, 12'h608));
        prog.push_back(ebreak_word());
        expect_write(32'h600, pj + 4);
        expect_write(32'h604, pa + 8);
        expect_write(32'h608, pa + 16);
        run_program(cycles);
        compare_writes();
    endtask

    task automatic test_halt_timing();
        int cycles;
        // the store after ebreak must never run
        prog = '{addi(1, 0, 1), addi(2, 1, 2), addi(3, 2, 3), addi(4, 3, 4),
                 addi(5, 4, 5), ebreak_word(), store_word(5, 0, 12'h7f0)};
        run_program(cycles);
        check_word("halted cycle", cycles, 1 + 6 * 5 + 4);
        repeat (20) @(negedge clock);
        check_word("halted", halted, 1);
        assert (wr_addr.size() == 0) else begin
            $display("data RAM written after the core halted");
            fail_stop();
        end
    endtask

    task automatic test_run_stall();
        word_t a;
        word_t b;
        int    free_cycles;
        int    stall_cycles;
        a = 32'h123;
        b = -69;
        prog = '{addi(1, 0, 12'h123), addi(2, 0, -69), r_type(0, 2, 1, funct3_add_sub, 3),
                 store_word(3, 0, 12'h700), r_type(32, 2, 1, funct3_add_sub, 4),
                 store_word(4, 0, 12'h704), ebreak_word()};
        with_stalls = 1'b0;
        run_program(free_cycles);
        expect_write(32'h700, a + b);
        expect_write(32'h704, a - b);
        compare_writes();
        with_stalls = 1'b1;
        run_program(stall_cycles);
        with_stalls = 1'b0;
        expect_write(32'h700, a + b);
        expect_write(32'h704, a - b);
        compare_writes();
        // fourteen stalled cycles in total
        check_word("stalled halt cycle", stall_cycles, free_cycles + 14);
    endtask

    initial begin
        reset_n              = 1'b0;
        run                  = 1'b1;
        inst_ram_read_result = '0;
        data_ram_read_result = '0;
        cycle_count          = 0;
        with_stalls          = 1'b0;
        fill_data_ram();
        test_arithmetic();
        test_shifts();
        test_load_store();
        test_control_flow();
        test_halt_timing();
        test_run_stall();
        $display("Verification passed");
        $finish;
    end

endmodule

//--- filelist.f
src/core_pkg.sv
src/isa_pkg.sv
src/reg_file_if.sv
src/register_file.sv
src/inst_decoder.sv
src/execute_unit.sv
src/core_control.sv
src/shader_core.sv
verif/shader_core_tb.sv

//--- Makefile
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --top-module shader_core_tb -f filelist.f -o shader_core_sim

run: compile
	./obj_dir/shader_core_sim | tee run.log
	grep -q "Verification passed" run.log

clean:
	rm -rf obj_dir run.log
